// ==== otp_scrmbl_settings.svh ====
// sizes for the OTP scrambling engine
// the key schedule in present_pkg is written for 128-bit keys only
// SCRMBL_SEL_W must cover both table sizes
`ifndef OTP_SCRMBL_SETTINGS_SVH
`define OTP_SCRMBL_SETTINGS_SVH

// cipher block and key width
`define SCRMBL_BLOCK_W 64
`define SCRMBL_KEY_W 128

// full PRESENT round count and width of the round index
`define SCRMBL_NUM_ROUNDS 31
`define SCRMBL_IDX_W 5

// constant table sizes
`define SCRMBL_NUM_KEYS 3
`define SCRMBL_NUM_DIGEST_SETS 2

// width of the table index input
`define SCRMBL_SEL_W 2

`endif

// ==== present_pkg.sv ====
// PRESENT-128 primitives for an iterative one-round datapath
// round index counts from 1 as in the cipher specification
`include "otp_scrmbl_settings.svh"

package present_pkg;

  typedef logic [`SCRMBL_BLOCK_W-1:0] block_t;
  typedef logic [`SCRMBL_KEY_W-1:0]   key_t;
  typedef logic [`SCRMBL_IDX_W-1:0]   round_idx_t;

  // 4-bit substitution table and its inverse with index 0 first
  localparam logic [3:0] SBOX [16] = '{
    4'hc, 4'h5, 4'h6, 4'hb, 4'h9, 4'h0, 4'ha, 4'hd,
    4'h3, 4'he, 4'hf, 4'h8, 4'h4, 4'h7, 4'h1, 4'h2
  };
  localparam logic [3:0] SBOX_INV [16] = '{
    4'h5, 4'he, 4'hf, 4'h8, 4'hc, 4'h1, 4'h2, 4'hd,
    4'hb, 4'h4, 4'h6, 4'h3, 4'h0, 4'h7, 4'h9, 4'ha
  };

  function automatic logic [3:0] sbox4(logic [3:0] x);
    return SBOX[x];
  endfunction

  function automatic logic [3:0] sbox4_inv(logic [3:0] x);
    return SBOX_INV[x];
  endfunction

  // bit i moves to 16*i mod 63 and the top bit stays put
  function automatic block_t perm64(block_t d);
    block_t p;
    for (int i = 0; i < 63; i++) begin
      p[(16 * i) % 63] = d[i];
    end
    p[63] = d[63];
    return p;
  endfunction

  function automatic block_t perm64_inv(block_t d);
    block_t p;
    for (int i = 0; i < 63; i++) begin
      p[i] = d[(16 * i) % 63];
    end
    p[63] = d[63];
    return p;
  endfunction

  // one forward key-schedule step
  // rotate left by 61, substitute the top two nibbles, add the round index
  function automatic key_t key_step_enc(key_t key, round_idx_t idx);
    key_t k;
    k = {key[66:0], key[127:67]};
    k[127:124] = sbox4(k[127:124]);
    k[123:120] = sbox4(k[123:120]);
    k[66:62]   = k[66:62] ^ idx;
    return k;
  endfunction

  // undoes key_step_enc for the same round index
  function automatic key_t key_step_dec(key_t key, round_idx_t idx);
    key_t k;
    k = key;
    k[66:62]   = k[66:62] ^ idx;
    k[127:124] = sbox4_inv(k[127:124]);
    k[123:120] = sbox4_inv(k[123:120]);
    return {k[60:0], k[127:61]};
  endfunction

  // key state after the last encryption round as start point for decryption
  function automatic key_t dec_key_for(key_t key);
    key_t k;
    k = key;
    for (int i = 1; i <= `SCRMBL_NUM_ROUNDS; i++) begin
      k = key_step_enc(k, round_idx_t'(i));
    end
    return k;
  endfunction

endpackage

// ==== otp_scrmbl_pkg.sv ====
// commands, FSM encoding and constant tables of the scrambling engine
// key index 0 is the all-zero key and serves as a known-answer entry
`include "otp_scrmbl_settings.svh"

package otp_scrmbl_pkg;
  import present_pkg::*;

  typedef enum logic [2:0] {
    CMD_DECRYPT         = 3'd0,
    CMD_ENCRYPT         = 3'd1,
    CMD_LOAD_SHADOW     = 3'd2,
    CMD_DIGEST          = 3'd3,
    CMD_DIGEST_INIT     = 3'd4,
    CMD_DIGEST_FINALIZE = 3'd5
  } scrmbl_cmd_e;

  // plain binary state encoding with idle as the reset value
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_DECRYPT = 2'd1,
    ST_ENCRYPT = 2'd2,
    ST_DIGEST  = 2'd3
  } ctrl_state_e;

  // data state register source
  typedef enum logic [2:0] {
    DATA_SEL_ENC_OUT = 3'd0,
    DATA_SEL_DEC_OUT = 3'd1,
    DATA_SEL_DIGEST  = 3'd2,
    DATA_SEL_ENC_XOR = 3'd3,
    DATA_SEL_INPUT   = 3'd4
  } data_sel_e;

  // key state register source
  typedef enum logic [2:0] {
    KEY_SEL_ENC_OUT      = 3'd0,
    KEY_SEL_DEC_OUT      = 3'd1,
    KEY_SEL_ENC_INIT     = 3'd2,
    KEY_SEL_DEC_INIT     = 3'd3,
    KEY_SEL_DIGEST_CONST = 3'd4,
    KEY_SEL_DIGEST_IN    = 3'd5
  } key_sel_e;

  localparam key_t KEY_TABLE [`SCRMBL_NUM_KEYS] = '{
    128'h0000_0000_0000_0000_0000_0000_0000_0000,
    128'h3ba1_2c7e_90d4_6f58_a2e1_7b0c_d963_45f2,
    128'hc4f0_8e27_1d5a_b396_0e7c_52a8_f41b_6d3e
  };

  localparam block_t DIGEST_IV_TABLE [`SCRMBL_NUM_DIGEST_SETS] = '{
    64'h90c7_f21f_6224_f027,
    64'h2b4e_81d6_a35f_07c9
  };

  localparam key_t DIGEST_CONST_TABLE [`SCRMBL_NUM_DIGEST_SETS] = '{
    128'hf98c_48b1_f937_7284_4a35_5f2b_c8d1_e06a,
    128'h7d16_e2a9_54c0_3bf8_91ae_0c67_d25b_48f3
  };

endpackage

// ==== present_round.sv ====
// one combinational PRESENT-128 round for encryption or decryption by parameter
// the final key addition is applied on the last round index only
// so R iterations from the first index give the complete cipher
`include "otp_scrmbl_settings.svh"

module present_round #(
  parameter bit decrypt_p = 1'b0
) (
  input  present_pkg::block_t     data_i,
  input  present_pkg::key_t       key_i,
  input  present_pkg::round_idx_t idx_i,
  output present_pkg::block_t     data_o,
  output present_pkg::key_t       key_o,
  output present_pkg::round_idx_t idx_o
);
  import present_pkg::*;

  // encryption runs 1..R upwards, decryption R..1 downwards
  localparam round_idx_t LAST_IDX = decrypt_p ? round_idx_t'(1) :
                                                round_idx_t'(`SCRMBL_NUM_ROUNDS);

  block_t data_tmp;
  key_t   key_tmp;

  always_comb begin : p_round
    // round key is the top half of the key state
    data_tmp = data_i ^ key_i[`SCRMBL_KEY_W-1 -: `SCRMBL_BLOCK_W];
    if (decrypt_p) begin
      key_tmp  = key_step_dec(key_i, idx_i);
      data_tmp = perm64_inv(data_tmp);
      for (int i = 0; i < `SCRMBL_BLOCK_W / 4; i++) begin
        data_tmp[4*i +: 4] = sbox4_inv(data_tmp[4*i +: 4]);
      end
      idx_o = idx_i - round_idx_t'(1);
    end else begin
      for (int i = 0; i < `SCRMBL_BLOCK_W / 4; i++) begin
        data_tmp[4*i +: 4] = sbox4(data_tmp[4*i +: 4]);
      end
      data_tmp = perm64(data_tmp);
      key_tmp  = key_step_enc(key_i, idx_i);
      idx_o    = idx_i + round_idx_t'(1);
    end
    // last round adds the stepped key to finish the cipher
    if (idx_i == LAST_IDX) begin
      data_tmp = data_tmp ^ key_tmp[`SCRMBL_KEY_W-1 -: `SCRMBL_BLOCK_W];
    end
    data_o = data_tmp;
    key_o  = key_tmp;
  end

endmodule

// ==== scrmbl_ctrl.sv ====
// command FSM of the scrambling engine with one cipher round per cycle
// commands are taken only in idle, nothing is queued
`include "otp_scrmbl_settings.svh"

module scrmbl_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  otp_scrmbl_pkg::scrmbl_cmd_e cmd_i,
  input  logic                        valid_i,
  output logic                        ready_o,
  output logic                        valid_o,
  output otp_scrmbl_pkg::data_sel_e   data_sel_o,
  output otp_scrmbl_pkg::key_sel_e    key_sel_o,
  output logic                        data_en_o,
  output logic                        key_en_o,
  output logic                        shadow_load_o,
  output logic                        digest_en_o,
  output logic                        digest_init_o
);
  import otp_scrmbl_pkg::*;

  localparam logic [`SCRMBL_IDX_W-1:0] LAST_CNT = `SCRMBL_IDX_W'(`SCRMBL_NUM_ROUNDS - 1);

  ctrl_state_e                state_d, state_q;
  logic [`SCRMBL_IDX_W-1:0]   cnt_d, cnt_q;
  logic                       valid_d, valid_q;

  assign ready_o = (state_q == ST_IDLE);
  assign valid_o = valid_q;

  always_comb begin : p_fsm
    state_d       = state_q;
    cnt_d         = cnt_q + 1'b1;
    valid_d       = 1'b0;
    data_sel_o    = DATA_SEL_INPUT;
    key_sel_o     = KEY_SEL_DIGEST_IN;
    data_en_o     = 1'b0;
    key_en_o      = 1'b0;
    shadow_load_o = 1'b0;
    digest_en_o   = 1'b0;
    digest_init_o = 1'b0;

    ////////////////////////////////////////////////////////////////////////////
    // idle decodes, round states iterate
    case (state_q)
      ST_IDLE: begin
        cnt_d = '0;
        if (valid_i) begin
          case (cmd_i)
            CMD_DECRYPT: begin
              state_d   = ST_DECRYPT;
              key_sel_o = KEY_SEL_DEC_INIT;
              data_en_o = 1'b1;
              key_en_o  = 1'b1;
            end
            CMD_ENCRYPT: begin
              state_d   = ST_ENCRYPT;
              key_sel_o = KEY_SEL_ENC_INIT;
              data_en_o = 1'b1;
              key_en_o  = 1'b1;
            end
            CMD_LOAD_SHADOW: shadow_load_o = 1'b1;
            // digest state is encrypted under the data block as key
            CMD_DIGEST: begin
              state_d    = ST_DIGEST;
              data_sel_o = DATA_SEL_DIGEST;
              data_en_o  = 1'b1;
              key_en_o   = 1'b1;
            end
            CMD_DIGEST_INIT: begin
              digest_init_o = 1'b1;
              digest_en_o   = 1'b1;
            end
            CMD_DIGEST_FINALIZE: begin
              state_d    = ST_DIGEST;
              data_sel_o = DATA_SEL_DIGEST;
              key_sel_o  = KEY_SEL_DIGEST_CONST;
              data_en_o  = 1'b1;
              key_en_o   = 1'b1;
            end
            default: state_d = ST_IDLE;
          endcase
        end
      end
      ST_DECRYPT, ST_ENCRYPT, ST_DIGEST: begin
        data_sel_o = (state_q == ST_DECRYPT) ? DATA_SEL_DEC_OUT : DATA_SEL_ENC_OUT;
        key_sel_o  = (state_q == ST_DECRYPT) ? KEY_SEL_DEC_OUT : KEY_SEL_ENC_OUT;
        data_en_o  = 1'b1;
        key_en_o   = 1'b1;
        if (cnt_q == LAST_CNT) begin
          state_d = ST_IDLE;
          valid_d = 1'b1;
          // Davies-Meyer feed-forward into its own register so encrypts can interleave
          if (state_q == ST_DIGEST) begin
            data_sel_o  = DATA_SEL_ENC_XOR;
            digest_en_o = 1'b1;
          end
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      valid_q <= valid_d;
    end
  end

  // a result is followed by at least one idle cycle
  valid_single_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |=> !valid_o);

endmodule

// ==== scrmbl_datapath.sv ====
// working registers and round logic of the scrambling engine
// digest input block is {data_i, shadow}, the digest state has its own register
// decryption keys are derived from the key table at elaboration
`include "otp_scrmbl_settings.svh"

module scrmbl_datapath (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [`SCRMBL_SEL_W-1:0]  sel_i,
  input  present_pkg::block_t       data_i,
  input  otp_scrmbl_pkg::data_sel_e data_sel_i,
  input  otp_scrmbl_pkg::key_sel_e  key_sel_i,
  input  logic                      data_en_i,
  input  logic                      key_en_i,
  input  logic                      shadow_load_i,
  input  logic                      digest_en_i,
  input  logic                      digest_init_i,
  input  logic                      valid_i,
  output present_pkg::block_t       data_o
);
  import present_pkg::*;
  import otp_scrmbl_pkg::*;

  key_t       key_state_d, key_state_q;
  round_idx_t idx_state_d, idx_state_q;
  block_t     data_state_d, data_state_q;
  block_t     digest_state_d, digest_state_q;
  block_t     shadow_q;
  block_t     enc_data_out, dec_data_out, enc_data_xor;
  key_t       enc_key_out, dec_key_out;
  round_idx_t enc_idx_out, dec_idx_out;
  key_t       enc_key_mux, dec_key_mux, digest_const_mux;
  block_t     digest_iv_mux;
  key_t       dec_key_lut [`SCRMBL_NUM_KEYS];

  ////////////////////////////////////////////////////////////////////////////
  // constant tables
  for (genvar k = 0; k < `SCRMBL_NUM_KEYS; k++) begin : gen_dec_keys
    localparam key_t DEC_KEY = dec_key_for(KEY_TABLE[k]);
    assign dec_key_lut[k] = DEC_KEY;
  end

  // out-of-range index reads zero
  always_comb begin : p_const_mux
    enc_key_mux      = '0;
    dec_key_mux      = '0;
    digest_const_mux = '0;
    digest_iv_mux    = '0;
    for (int k = 0; k < `SCRMBL_NUM_KEYS; k++) begin
      if (sel_i == `SCRMBL_SEL_W'(k)) begin
        enc_key_mux = KEY_TABLE[k];
        dec_key_mux = dec_key_lut[k];
      end
    end
    for (int k = 0; k < `SCRMBL_NUM_DIGEST_SETS; k++) begin
      if (sel_i == `SCRMBL_SEL_W'(k)) begin
        digest_const_mux = DIGEST_CONST_TABLE[k];
        digest_iv_mux    = DIGEST_IV_TABLE[k];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // state muxes
  assign enc_data_xor   = enc_data_out ^ digest_state_q;
  assign digest_state_d = digest_init_i ? digest_iv_mux : enc_data_xor;

  always_comb begin : p_data_mux
    case (data_sel_i)
      DATA_SEL_ENC_OUT: data_state_d = enc_data_out;
      DATA_SEL_DEC_OUT: data_state_d = dec_data_out;
      DATA_SEL_DIGEST:  data_state_d = digest_state_q;
      DATA_SEL_ENC_XOR: data_state_d = enc_data_xor;
      default:          data_state_d = data_i;
    endcase
  end

  // index starts at 1 except for decryption, which counts down from R
  always_comb begin : p_key_mux
    idx_state_d = round_idx_t'(1);
    case (key_sel_i)
      KEY_SEL_ENC_OUT: begin
        key_state_d = enc_key_out;
        idx_state_d = enc_idx_out;
      end
      KEY_SEL_DEC_OUT: begin
        key_state_d = dec_key_out;
        idx_state_d = dec_idx_out;
      end
      KEY_SEL_ENC_INIT: key_state_d = enc_key_mux;
      KEY_SEL_DEC_INIT: begin
        key_state_d = dec_key_mux;
        idx_state_d = round_idx_t'(`SCRMBL_NUM_ROUNDS);
      end
      KEY_SEL_DIGEST_CONST: key_state_d = digest_const_mux;
      default: key_state_d = {data_i, shadow_q};
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // round instances
  present_round #(
    .decrypt_p(1'b0)
  ) u_round_enc (
    .data_i(data_state_q),
    .key_i (key_state_q),
    .idx_i (idx_state_q),
    .data_o(enc_data_out),
    .key_o (enc_key_out),
    .idx_o (enc_idx_out)
  );

  present_round #(
    .decrypt_p(1'b1)
  ) u_round_dec (
    .data_i(data_state_q),
    .key_i (key_state_q),
    .idx_i (idx_state_q),
    .data_o(dec_data_out),
    .key_o (dec_key_out),
    .idx_o (dec_idx_out)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      key_state_q    <= '0;
      idx_state_q    <= '0;
      data_state_q   <= '0;
      digest_state_q <= '0;
      shadow_q       <= '0;
    end else begin
      if (key_en_i) begin
        key_state_q <= key_state_d;
        idx_state_q <= idx_state_d;
      end
      if (data_en_i) begin
        data_state_q <= data_state_d;
      end
      if (digest_en_i) begin
        digest_state_q <= digest_state_d;
      end
      if (shadow_load_i) begin
        shadow_q <= data_i;
      end
    end
  end

  // result is visible only during the valid pulse
  assign data_o = valid_i ? data_state_q : '0;

  // table index from outside must fit the table the controller picks
  key_sel_range_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    key_en_i && (key_sel_i inside {KEY_SEL_ENC_INIT, KEY_SEL_DEC_INIT})
    |-> sel_i < `SCRMBL_NUM_KEYS);
  digest_sel_range_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (key_en_i && key_sel_i == KEY_SEL_DIGEST_CONST) || digest_init_i
    |-> sel_i < `SCRMBL_NUM_DIGEST_SETS);

endmodule

// ==== otp_scrmbl.sv ====
// PRESENT-128 scrambling engine for the OTP controller
// fixed latency of SCRMBL_NUM_ROUNDS cycles from accept to valid_o
`include "otp_scrmbl_settings.svh"

module otp_scrmbl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  otp_scrmbl_pkg::scrmbl_cmd_e cmd_i,
  input  logic [`SCRMBL_SEL_W-1:0]    sel_i,
  input  present_pkg::block_t         data_i,
  input  logic                        valid_i,
  output logic                        ready_o,
  output present_pkg::block_t         data_o,
  output logic                        valid_o
);
  import otp_scrmbl_pkg::*;

  // controller to datapath steering
  data_sel_e data_sel;
  key_sel_e  key_sel;
  logic      data_en;
  logic      key_en;
  logic      shadow_load;
  logic      digest_en;
  logic      digest_init;

  scrmbl_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_i        (cmd_i),
    .valid_i      (valid_i),
    .ready_o      (ready_o),
    .valid_o      (valid_o),
    .data_sel_o   (data_sel),
    .key_sel_o    (key_sel),
    .data_en_o    (data_en),
    .key_en_o     (key_en),
    .shadow_load_o(shadow_load),
    .digest_en_o  (digest_en),
    .digest_init_o(digest_init)
  );

  // valid_o also gates the data output
  scrmbl_datapath u_datapath (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .sel_i        (sel_i),
    .data_i       (data_i),
    .data_sel_i   (data_sel),
    .key_sel_i    (key_sel),
    .data_en_i    (data_en),
    .key_en_i     (key_en),
    .shadow_load_i(shadow_load),
    .digest_en_i  (digest_en),
    .digest_init_i(digest_init),
    .valid_i      (valid_o),
    .data_o       (data_o)
  );

endmodule

// ==== tb_otp_scrmbl.sv ====
// testbench for the OTP scrambling engine
// concurrent assertions sampled on the falling clock edge do all checking
// digest results are compared run against run, not against fixed values
`include "otp_scrmbl_settings.svh"

module tb_otp_scrmbl;
  timeunit 1ns;
  timeprecision 1ps;

  import present_pkg::*;
  import otp_scrmbl_pkg::*;

  localparam int ROUNDS  = `SCRMBL_NUM_ROUNDS;
  localparam int TIMEOUT = 100;

  // published PRESENT-128 vector for the all-zero key and block
  localparam int     KAT_KEY_IDX = 0;
  localparam block_t KAT_CT      = 64'h96db702a2e6900af;

  logic                     clk_i;
  logic                     rst_ni;
  scrmbl_cmd_e              cmd_i;
  logic [`SCRMBL_SEL_W-1:0] sel_i;
  block_t                   data_i;
  logic                     valid_i;
  logic                     ready_o;
  block_t                   data_o;
  logic                     valid_o;

  // expected handshake derived from the accept rule and the round count
  int unsigned rounds_left;
  logic        pulse_exp;
  // result check selection
  logic        chk_eq;
  logic        chk_ne;
  block_t      exp_data;

  int unsigned errors;
  int unsigned tests_run;
  int unsigned tests_failed;

  otp_scrmbl i_dut (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .cmd_i  (cmd_i),
    .sel_i  (sel_i),
    .data_i (data_i),
    .valid_i(valid_i),
    .ready_o(ready_o),
    .data_o (data_o),
    .valid_o(valid_o)
  );

  always #5ns clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // reference for ready and valid timing

  function automatic logic runs_rounds(scrmbl_cmd_e cmd);
    return cmd inside {CMD_ENCRYPT, CMD_DECRYPT, CMD_DIGEST, CMD_DIGEST_FINALIZE};
  endfunction

  // accept edge loads R, pulse follows the edge that reaches zero
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_expect
    if (!rst_ni) begin
      rounds_left <= 0;
      pulse_exp   <= 1'b0;
    end else begin
      pulse_exp <= (rounds_left == 1);
      if (rounds_left != 0) begin
        rounds_left <= rounds_left - 1;
      end else if (valid_i && runs_rounds(cmd_i)) begin
        rounds_left <= ROUNDS;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks

  ready_check_a: assert property (@(negedge clk_i) disable iff (!rst_ni)
    ready_o == (rounds_left == 0))
    else begin
      errors++;
      $display("Mismatch ready_o: got %h expected %h", ready_o, (rounds_left == 0));
    end

  valid_check_a: assert property (@(negedge clk_i) disable iff (!rst_ni)
    valid_o == pulse_exp)
    else begin
      errors++;
      $display("Mismatch valid_o: got %h expected %h", valid_o, pulse_exp);
    end

  idle_zero_a: assert property (@(negedge clk_i) disable iff (!rst_ni)
    !valid_o |-> data_o == '0)
    else begin
      errors++;
      $display("Mismatch data_o: got %h expected %h while idle", data_o, 64'h0);
    end

  result_eq_a: assert property (@(negedge clk_i) disable iff (!rst_ni)
    valid_o && chk_eq |-> data_o == exp_data)
    else begin
      errors++;
      $display("Mismatch data_o: got %h expected %h", data_o, exp_data);
    end

  result_ne_a: assert property (@(negedge clk_i) disable iff (!rst_ni)
    valid_o && chk_ne |-> data_o != exp_data)
    else begin
      errors++;
      $display("Mismatch data_o: got %h expected a value other than %h", data_o, exp_data);
    end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  // mode 0 no check, 1 result equals value, 2 result differs from value
  task automatic set_check(input int mode, input block_t value);
    chk_eq   = (mode == 1);
    chk_ne   = (mode == 2);
    exp_data = value;
  endtask

  // returns on the accepting edge
  task automatic issue(input scrmbl_cmd_e cmd, input int sel, input block_t data);
    @(posedge clk_i);
    cmd_i   <= cmd;
    sel_i   <= sel[`SCRMBL_SEL_W-1:0];
    data_i  <= data;
    valid_i <= 1'b1;
    @(posedge clk_i);
    valid_i <= 1'b0;
  endtask

  task automatic wait_result(output block_t res);
    int unsigned n;
    bit          seen;
    n    = 0;
    seen = 1'b0;
    res  = '0;
    while (!seen && n < TIMEOUT) begin
      @(negedge clk_i);
      if (valid_o) begin
        seen = 1'b1;
        res  = data_o;
      end
      n++;
    end
    if (seen) begin
      // step past the pulse before the check selection may change
      @(negedge clk_i);
    end else begin
      errors++;
      $display("timeout: valid_o did not rise within %0d cycles", TIMEOUT);
    end
  endtask

  task automatic run_cmd(input scrmbl_cmd_e cmd, input int sel, input block_t data,
                         output block_t res);
    issue(cmd, sel, data);
    wait_result(res);
  endtask

  // init, two shadow/digest steps and finalize, optionally with encrypts in between
  task automatic digest_run(input block_t words [4], input bit interleave, input int mode,
                            input block_t ref_val, output block_t res);
    block_t scratch;
    set_check(0, '0);
    issue(CMD_DIGEST_INIT, 1, '0);
    for (int i = 0; i < 2; i++) begin
      issue(CMD_LOAD_SHADOW, 0, words[2*i]);
      if (interleave) begin
        run_cmd(CMD_ENCRYPT, i + 1, ~words[2*i+1], scratch);
      end
      run_cmd(CMD_DIGEST, 0, words[2*i+1], scratch);
    end
    if (interleave) begin
      run_cmd(CMD_DECRYPT, 2, words[0], scratch);
    end
    set_check(mode, ref_val);
    run_cmd(CMD_DIGEST_FINALIZE, 1, '0, res);
    set_check(0, '0);
  endtask

  task automatic end_test(input string name, input int unsigned err_mark);
    tests_run++;
    if (errors != err_mark) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  initial begin : p_main
    block_t      pt;
    block_t      ct;
    block_t      res;
    block_t      res_ref;
    block_t      words [4];
    int unsigned mark;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    cmd_i        = CMD_ENCRYPT;
    sel_i        = '0;
    data_i       = '0;
    valid_i      = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    set_check(0, '0);
    void'($urandom(32'ha7498431));
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (2) @(posedge clk_i);

    // all-zero key and block against the published vector
    mark = errors;
    set_check(1, KAT_CT);
    run_cmd(CMD_ENCRYPT, KAT_KEY_IDX, '0, ct);
    set_check(1, '0);
    run_cmd(CMD_DECRYPT, KAT_KEY_IDX, KAT_CT, pt);
    set_check(0, '0);
    end_test("known_answer", mark);

    mark = errors;
    for (int k = 0; k < `SCRMBL_NUM_KEYS; k++) begin
      for (int n = 0; n < 4; n++) begin
        pt = {$urandom, $urandom};
        set_check(0, '0);
        run_cmd(CMD_ENCRYPT, k, pt, ct);
        set_check(1, pt);
        run_cmd(CMD_DECRYPT, k, ct, res);
      end
    end
    set_check(0, '0);
    end_test("round_trip", mark);

    // consecutive commands, latency and pulse width by the timing checks
    mark = errors;
    for (int n = 0; n < 3; n++) begin
      run_cmd(n[0] ? CMD_DECRYPT : CMD_ENCRYPT, n, {$urandom, $urandom}, res);
    end
    end_test("timing", mark);

    // commands while busy are dropped, short commands give no pulse
    mark = errors;
    pt = {$urandom, $urandom};
    set_check(1, KAT_CT);
    issue(CMD_ENCRYPT, KAT_KEY_IDX, '0);
    @(posedge clk_i);
    cmd_i   <= CMD_DECRYPT;
    sel_i   <= 2'd2;
    data_i  <= ~pt;
    valid_i <= 1'b1;
    repeat (5) @(posedge clk_i);
    valid_i <= 1'b0;
    wait_result(res);
    set_check(0, '0);
    issue(CMD_LOAD_SHADOW, 0, pt);
    issue(CMD_DIGEST_INIT, 0, '0);
    repeat (ROUNDS + 4) @(posedge clk_i);
    end_test("ignored_commands", mark);

    mark = errors;
    for (int i = 0; i < 4; i++) begin
      words[i] = {$urandom, $urandom};
    end
    digest_run(words, 1'b0, 0, '0, res_ref);
    digest_run(words, 1'b1, 1, res_ref, res);
    words[3] = words[3] ^ 64'h1;
    digest_run(words, 1'b0, 2, res_ref, res);
    end_test("digest", mark);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== otp_scrmbl.f ====
+incdir+.
present_pkg.sv
otp_scrmbl_pkg.sv
present_round.sv
scrmbl_ctrl.sv
scrmbl_datapath.sv
otp_scrmbl.sv
tb_otp_scrmbl.sv

// ==== Makefile ====
# Verilator flow for the OTP scrambling engine

TOP = tb_otp_scrmbl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module otp_scrmbl -f otp_scrmbl.f

# the run passes only if the pass line shows up in the output
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f otp_scrmbl.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf obj_dir
